// ==== trig_cfg_pkg.sv ====
// --------------------
// configuration and occupancy types
// channel count, capacity, register map
// --------------------

package trig_cfg_pkg;

  localparam int num_chan = 5;

  // event size limit in asynchronous mode, in bursts per channel
  localparam int unsigned ddr3_capacity = 524288;

  typedef logic [22:0] burst_cnt_t;
  typedef logic [num_chan-1:0] chan_mask_t;
  typedef logic [31:0] ovf_cnt_t;
  typedef logic [3:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // word addresses
  localparam wb_addr_t reg_chan_en     = 4'd0;
  localparam wb_addr_t reg_thres       = 4'd1;
  localparam wb_addr_t reg_burst_base  = 4'd2;  // one word per channel
  localparam wb_addr_t reg_ovf_count   = 4'd8;
  localparam wb_addr_t reg_trig_num    = 4'd9;
  localparam wb_addr_t reg_almost_full = 4'd10;

endpackage

// ==== trig_rec_pkg.sv ====
// --------------------
// trigger record, length codes
// state enum and counter types
// --------------------

package trig_rec_pkg;

  typedef logic [23:0] trig_num_t;
  typedef logic [43:0] timestamp_t;
  typedef logic [1:0] trig_len_t;

  // pulse length codes
  localparam trig_len_t len_laser = 2'd2;  // short pulse
  localparam trig_len_t len_am    = 2'd1;  // long pulse
  localparam trig_len_t len_both  = 2'd3;

  // {length, number, timestamp}
  typedef logic [69:0] trig_rec_t;

  typedef logic [3:0] wait_cnt_t;

  typedef enum logic [1:0] {
    idle,
    send_trigger,
    wait_level,
    store_info
  } trig_state_t;

endpackage

// ==== chan_occ_if.sv ====
// --------------------
// one channel's config, events, status
// --------------------

interface chan_occ_if;

  logic                    enable;
  trig_cfg_pkg::burst_cnt_t burst_count;  // bursts per trigger minus one
  trig_cfg_pkg::burst_cnt_t thres;
  logic                    launch;  // one cycle per accepted trigger
  logic                    clear;   // readout finished
  trig_cfg_pkg::burst_cnt_t stored;
  logic                    full;
  logic                    almost_full;

  // register block side
  modport cfg (
    output enable, burst_count, thres,
    input  stored, almost_full
  );

  // trigger state machine side
  modport ctl (
    output launch, clear,
    input  full
  );

  // occupancy tracker side
  modport chan (
    input  enable, burst_count, thres, launch, clear,
    output stored, full, almost_full
  );

endinterface

// ==== trig_config_regs.sv ====
// --------------------
// wishbone classic config registers
// --------------------

module trig_config_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  trig_cfg_pkg::wb_addr_t wb_adr,
  input  trig_cfg_pkg::wb_data_t wb_dat_w,
  output trig_cfg_pkg::wb_data_t wb_dat_r,
  output logic                   wb_ack,
  input  trig_cfg_pkg::ovf_cnt_t ddr3_overflow_count,
  input  trig_rec_pkg::trig_num_t trig_num,
  chan_occ_if.cfg                occ [trig_cfg_pkg::num_chan]
);

  trig_cfg_pkg::chan_mask_t chan_en;
  trig_cfg_pkg::burst_cnt_t thres_reg;
  trig_cfg_pkg::burst_cnt_t burst_set [trig_cfg_pkg::num_chan];
  trig_cfg_pkg::chan_mask_t af_mask;  // gathered from trackers
  trig_cfg_pkg::wb_data_t   rd_word;
  logic                     wb_hit;

  // new request, not yet acknowledged
  assign wb_hit = wb_cyc && wb_stb && !wb_ack;

  // fan out config, collect status
  for (genvar i = 0; i < trig_cfg_pkg::num_chan; i++) begin : g_chan
    assign occ[i].enable      = chan_en[i];
    assign occ[i].burst_count = burst_set[i];
    assign occ[i].thres       = thres_reg;
    assign af_mask[i]         = occ[i].almost_full;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack    <= 1'b0;
      chan_en   <= '0;
      thres_reg <= '0;
      for (int i = 0; i < trig_cfg_pkg::num_chan; i++) begin
        burst_set[i] <= '0;
      end
    end else begin
      wb_ack <= wb_hit;
      if (wb_hit && wb_we) begin
        if (wb_adr == trig_cfg_pkg::reg_chan_en)
          chan_en <= trig_cfg_pkg::chan_mask_t'(wb_dat_w);
        if (wb_adr == trig_cfg_pkg::reg_thres)
          thres_reg <= trig_cfg_pkg::burst_cnt_t'(wb_dat_w);
        for (int i = 0; i < trig_cfg_pkg::num_chan; i++) begin
          if (wb_adr == trig_cfg_pkg::wb_addr_t'(trig_cfg_pkg::reg_burst_base + i))
            burst_set[i] <= trig_cfg_pkg::burst_cnt_t'(wb_dat_w);
        end
      end
    end
  end

  // read mux, unmapped words read zero
  always_comb begin
    rd_word = '0;
    case (wb_adr)
      trig_cfg_pkg::reg_chan_en:     rd_word = trig_cfg_pkg::wb_data_t'(chan_en);
      trig_cfg_pkg::reg_thres:       rd_word = trig_cfg_pkg::wb_data_t'(thres_reg);
      trig_cfg_pkg::reg_ovf_count:   rd_word = ddr3_overflow_count;
      trig_cfg_pkg::reg_trig_num:    rd_word = trig_cfg_pkg::wb_data_t'(trig_num);
      trig_cfg_pkg::reg_almost_full: rd_word = trig_cfg_pkg::wb_data_t'(af_mask);
      default: begin
        for (int i = 0; i < trig_cfg_pkg::num_chan; i++) begin
          if (wb_adr == trig_cfg_pkg::wb_addr_t'(trig_cfg_pkg::reg_burst_base + i))
            rd_word = trig_cfg_pkg::wb_data_t'(burst_set[i]);
        end
      end
    endcase
  end

  // captured with the ack edge, valid while ack is high
  always_ff @(posedge clk) begin
    if (wb_hit) begin
      wb_dat_r <= rd_word;
    end
  end

endmodule

// ==== chan_occupancy.sv ====
// --------------------
// per-channel stored burst counter
// --------------------

module chan_occupancy (
  input logic      clk,
  input logic      reset,
  chan_occ_if.chan occ
);

  logic [23:0] need;     // bursts one trigger adds
  logic [23:0] after;    // stored count if one more trigger lands

  assign need  = {1'b0, occ.burst_count} + 24'd1;
  assign after = {1'b0, occ.stored} + need;

  always_ff @(posedge clk) begin
    if (reset || occ.clear) begin
      occ.stored <= '0;
    end else if (occ.launch && occ.enable) begin
      occ.stored <= occ.stored + trig_cfg_pkg::burst_cnt_t'(need);
    end
  end

  // same as capacity - stored < need, without the underflow
  assign occ.full = occ.enable && (after > 24'(trig_cfg_pkg::ddr3_capacity));

  assign occ.almost_full = occ.stored > occ.thres;

endmodule

// ==== pulse_trigger_fsm.sv ====
// --------------------
// trigger acceptance, length classification
// numbering, timestamps, record hand-off
// --------------------

module pulse_trigger_fsm (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    trigger,
  input  logic                    reset_trig_num,
  input  logic                    reset_trig_timestamp,
  input  logic                    readout_done,
  input  logic                    rec_ready,
  output logic                    pulse_trigger,
  output logic                    rec_valid,
  output trig_rec_pkg::trig_rec_t rec_data,
  output trig_rec_pkg::trig_num_t trig_num,
  output trig_cfg_pkg::ovf_cnt_t  ddr3_overflow_count,
  chan_occ_if.ctl                 occ [trig_cfg_pkg::num_chan]
);

  trig_rec_pkg::trig_state_t state;
  trig_rec_pkg::wait_cnt_t   wait_cnt;
  logic [2:0]                trig_hist;  // first three trigger samples
  trig_rec_pkg::timestamp_t  ts_cnt;     // cycles since timestamp reset
  trig_rec_pkg::trig_len_t   rec_len;
  trig_rec_pkg::trig_num_t   rec_num;
  trig_rec_pkg::timestamp_t  rec_ts;
  trig_cfg_pkg::chan_mask_t  full_mask;
  logic                      any_full;
  logic                      accept;

  for (genvar i = 0; i < trig_cfg_pkg::num_chan; i++) begin : g_chan
    assign full_mask[i]  = occ[i].full;
    assign occ[i].launch = pulse_trigger;
    assign occ[i].clear  = readout_done || reset;
  end

  assign any_full = |full_mask;
  assign accept   = (state == trig_rec_pkg::idle) && trigger && !any_full;

  assign pulse_trigger = (state == trig_rec_pkg::send_trigger);

  assign rec_data = {rec_len, rec_num, rec_ts};

  // control path
  always_ff @(posedge clk) begin
    if (reset) begin
      state               <= trig_rec_pkg::idle;
      wait_cnt            <= '0;
      trig_hist           <= '0;
      ddr3_overflow_count <= '0;
    end else begin
      case (state)
        trig_rec_pkg::idle: begin
          if (trigger && any_full) begin
            ddr3_overflow_count <= ddr3_overflow_count + 1'b1;  // dropped
          end else if (trigger) begin
            trig_hist <= 3'b001;  // first sample
            wait_cnt  <= 4'd1;
            state     <= trig_rec_pkg::send_trigger;
          end
        end
        trig_rec_pkg::send_trigger: begin
          trig_hist[1] <= trigger;
          wait_cnt     <= 4'd2;
          state        <= trig_rec_pkg::wait_level;
        end
        trig_rec_pkg::wait_level: begin
          case (wait_cnt)
            4'd2: begin
              trig_hist[2] <= trigger;
              wait_cnt     <= 4'd3;
            end
            4'd3: wait_cnt <= 4'd4;  // length decided on this edge
            default: state <= trig_rec_pkg::store_info;
          endcase
        end
        trig_rec_pkg::store_info: begin
          if (rec_valid && rec_ready) begin
            wait_cnt  <= '0;
            trig_hist <= '0;
            state     <= trig_rec_pkg::idle;
          end
        end
        default: state <= trig_rec_pkg::idle;
      endcase
    end
  end

  // record valid, one cycle after entering store_info
  always_ff @(posedge clk) begin
    if (reset) begin
      rec_valid <= 1'b0;
    end else if (rec_valid && rec_ready) begin
      rec_valid <= 1'b0;
    end else if (state == trig_rec_pkg::store_info) begin
      rec_valid <= 1'b1;
    end
  end

  // record fields
  always_ff @(posedge clk) begin
    if (accept) begin
      rec_ts  <= ts_cnt;
      rec_num <= trig_num + 1'b1;
    end
    if (state == trig_rec_pkg::wait_level && wait_cnt == 4'd3) begin
      if (!trigger)
        rec_len <= trig_rec_pkg::len_laser;  // ended before the fourth sample
      else if (trig_hist == 3'b111)
        rec_len <= trig_rec_pkg::len_am;
      else
        rec_len <= trig_rec_pkg::len_both;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || reset_trig_num || readout_done) begin
      trig_num <= '0;
    end else if (accept) begin
      trig_num <= trig_num + 1'b1;
    end
  end

  // free running timestamp
  always_ff @(posedge clk) begin
    if (reset || reset_trig_timestamp) begin
      ts_cnt <= '0;
    end else begin
      ts_cnt <= ts_cnt + 1'b1;
    end
  end

endmodule

// ==== pulse_trigger_top.sv ====
// --------------------
// pulse trigger receiver top level
// --------------------

module pulse_trigger_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  trig_cfg_pkg::wb_addr_t  wb_adr,
  input  trig_cfg_pkg::wb_data_t  wb_dat_w,
  output trig_cfg_pkg::wb_data_t  wb_dat_r,
  output logic                    wb_ack,
  input  logic                    trigger,
  input  logic                    reset_trig_num,
  input  logic                    reset_trig_timestamp,
  input  logic                    readout_done,
  output logic                    pulse_trigger,
  output logic                    rec_valid,
  input  logic                    rec_ready,
  output trig_rec_pkg::trig_rec_t rec_data,
  output logic                    ddr3_almost_full,
  output trig_cfg_pkg::ovf_cnt_t  ddr3_overflow_count
);

  trig_rec_pkg::trig_num_t  trig_num;
  trig_cfg_pkg::chan_mask_t af_mask;

  chan_occ_if occ_if [trig_cfg_pkg::num_chan] ();

  trig_config_regs trig_config_regs_i (
    .clk                 (clk),
    .reset               (reset),
    .wb_cyc              (wb_cyc),
    .wb_stb              (wb_stb),
    .wb_we               (wb_we),
    .wb_adr              (wb_adr),
    .wb_dat_w            (wb_dat_w),
    .wb_dat_r            (wb_dat_r),
    .wb_ack              (wb_ack),
    .ddr3_overflow_count (ddr3_overflow_count),
    .trig_num            (trig_num),
    .occ                 (occ_if)
  );

  pulse_trigger_fsm pulse_trigger_fsm_i (
    .clk                  (clk),
    .reset                (reset),
    .trigger              (trigger),
    .reset_trig_num       (reset_trig_num),
    .reset_trig_timestamp (reset_trig_timestamp),
    .readout_done         (readout_done),
    .rec_ready            (rec_ready),
    .pulse_trigger        (pulse_trigger),
    .rec_valid            (rec_valid),
    .rec_data             (rec_data),
    .trig_num             (trig_num),
    .ddr3_overflow_count  (ddr3_overflow_count),
    .occ                  (occ_if)
  );

  for (genvar i = 0; i < trig_cfg_pkg::num_chan; i++) begin : g_chan
    chan_occupancy chan_occupancy_i (
      .clk   (clk),
      .reset (reset),
      .occ   (occ_if[i])
    );
    assign af_mask[i] = occ_if[i].almost_full;
  end

  // warning if any channel is past its threshold
  assign ddr3_almost_full = |af_mask;

endmodule

// ==== pulse_trigger_checker.sv ====
// --------------------
// record port, trigger pulse, wishbone assertions
// --------------------

module pulse_trigger_checker (
  input logic                    clk,
  input logic                    reset,
  input logic                    rec_valid,
  input logic                    rec_ready,
  input trig_rec_pkg::trig_rec_t rec_data,
  input logic                    pulse_trigger,
  input logic                    wb_cyc,
  input logic                    wb_stb,
  input logic                    wb_ack
);

  int unsigned fail_count = 0;  // assertion failures so far

  // record held until taken
  a_rec_stable: assert property (@(posedge clk) disable iff (reset)
    rec_valid && !rec_ready |=> rec_valid && $stable(rec_data))
    else begin
      $error("record changed or dropped while stalled");
      fail_count++;
    end

  a_pulse_one: assert property (@(posedge clk) disable iff (reset)
    pulse_trigger |=> !pulse_trigger)
    else begin
      $error("pulse_trigger high for two cycles");
      fail_count++;
    end

  a_ack_one: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack high for two cycles");
      fail_count++;
    end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> wb_cyc && wb_stb)  // only inside a bus cycle
    else begin
      $error("wb_ack outside a bus cycle");
      fail_count++;
    end

endmodule

bind pulse_trigger_top pulse_trigger_checker pulse_trigger_checker_i (
  .clk           (clk),
  .reset         (reset),
  .rec_valid     (rec_valid),
  .rec_ready     (rec_ready),
  .rec_data      (rec_data),
  .pulse_trigger (pulse_trigger),
  .wb_cyc        (wb_cyc),
  .wb_stb        (wb_stb),
  .wb_ack        (wb_ack)
);

// ==== tb_pulse_trigger.sv ====
// --------------------
// pulse trigger receiver testbench
// --------------------

module tb_pulse_trigger;

  localparam int cycle_limit = 5 + 150 + 500 + 200 + 200 + 200 + 400;  // phases plus margin

  logic clk, reset, wb_cyc, wb_stb, wb_we, wb_ack;
  trig_cfg_pkg::wb_addr_t  wb_adr;
  trig_cfg_pkg::wb_data_t  wb_dat_w, wb_dat_r;
  logic trigger, reset_trig_num, reset_trig_timestamp, readout_done;
  logic pulse_trigger, rec_valid, rec_ready, ddr3_almost_full, stall_en;
  trig_rec_pkg::trig_rec_t rec_data;
  trig_cfg_pkg::ovf_cnt_t  ddr3_overflow_count;

  integer seed = 32'he46bad02;
  int cycles, rec_errs, word_errs, flag_errs, other_errs, assert_errs, w;
  trig_rec_pkg::trig_rec_t rec_q [$];  // expected records in order

  // reference model state
  logic m_idle, hs;
  int k;
  logic [3:0] smp;
  trig_rec_pkg::trig_num_t  m_num, rec_num;
  trig_rec_pkg::timestamp_t m_ts, rec_ts;
  trig_cfg_pkg::ovf_cnt_t   m_ovf;
  trig_cfg_pkg::chan_mask_t m_en;
  trig_cfg_pkg::burst_cnt_t m_thres;
  trig_cfg_pkg::burst_cnt_t m_burst [trig_cfg_pkg::num_chan];
  longint m_stored [trig_cfg_pkg::num_chan];

  pulse_trigger_top pulse_trigger_top_i (.*);

  function automatic trig_rec_pkg::trig_rec_t expected_rec(input logic [3:0] s,
      input trig_rec_pkg::trig_num_t n, input trig_rec_pkg::timestamp_t ts);
    trig_rec_pkg::trig_len_t len;
    if (!s[3]) len = trig_rec_pkg::len_laser;
    else if (s[2:0] == 3'b111) len = trig_rec_pkg::len_am;
    else len = trig_rec_pkg::len_both;
    return {len, n, ts};
  endfunction

  function automatic logic model_full();
    logic f = 1'b0;
    for (int i = 0; i < trig_cfg_pkg::num_chan; i++)
      if (m_en[i] && (longint'(trig_cfg_pkg::ddr3_capacity) - m_stored[i] < m_burst[i] + 1))
        f = 1'b1;
    return f;
  endfunction

  function automatic trig_cfg_pkg::chan_mask_t model_af();
    trig_cfg_pkg::chan_mask_t m;
    for (int i = 0; i < trig_cfg_pkg::num_chan; i++) m[i] = m_stored[i] > m_thres;
    return m;
  endfunction

  task automatic check_rec(input trig_rec_pkg::trig_rec_t got, exp, input string name);
    if (got !== exp) begin
      rec_errs++;
      $display("[FAIL] t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input trig_cfg_pkg::wb_data_t got, exp, input string name);
    if (got !== exp) begin
      word_errs++;
      $display("[FAIL] t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, exp, input string name);
    if (got !== exp) begin
      flag_errs++;
      $display("[FAIL] t=%0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // cycle limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // random back-pressure on the record port
  always @(posedge clk) rec_ready <= stall_en ? (($random(seed) & 3) != 0) : 1'b1;

  // model update and compare
  always @(posedge clk) begin
    if (reset) begin
      m_idle = 1'b1;
      k = 0;
      m_num = '0;
      m_ts = '0;
      m_ovf = '0;
      for (int i = 0; i < trig_cfg_pkg::num_chan; i++) m_stored[i] = 0;
    end else begin
      check_flag(pulse_trigger, k == 1, "pulse_trigger");  // cycle after acceptance
      check_word(ddr3_overflow_count, m_ovf, "ddr3_overflow_count");
      hs = rec_valid && rec_ready;
      if (hs) begin
        if (rec_q.size() == 0) begin
          other_errs++;
          $display("unexpected record %h at t=%0t", rec_data, $time);
        end else begin
          check_rec(rec_data, rec_q.pop_front(), "rec_data");
        end
      end
      for (int i = 0; i < trig_cfg_pkg::num_chan; i++) begin
        if (readout_done) m_stored[i] = 0;
        else if (k == 1 && m_en[i]) m_stored[i] += m_burst[i] + 1;  // launch edge
      end
      if (m_idle) begin
        if (trigger && model_full()) begin
          m_ovf++;
        end else if (trigger) begin
          m_idle = 1'b0;
          smp[0] = 1'b1;
          k = 1;
          rec_num = m_num + 1'b1;
          rec_ts = m_ts;
        end
      end else if (k >= 1 && k <= 3) begin
        smp[k] = trigger;
        k++;
        if (k == 4) rec_q.push_back(expected_rec(smp, rec_num, rec_ts));
      end else if (k == 4 && hs) begin
        m_idle = 1'b1;
        k = 0;
      end
      if (reset_trig_num || readout_done) m_num = '0;
      else if (k == 1 && rec_num == m_num + 1'b1) m_num = rec_num;
      m_ts = reset_trig_timestamp ? '0 : m_ts + 1'b1;
    end
  end

  task automatic wb_access(input logic we, input trig_cfg_pkg::wb_addr_t a,
      input trig_cfg_pkg::wb_data_t d, output trig_cfg_pkg::wb_data_t rd);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= a;
    wb_dat_w <= d;
    do @(posedge clk); while (!wb_ack);
    rd = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  task automatic write_reg(input trig_cfg_pkg::wb_addr_t a, input trig_cfg_pkg::wb_data_t d);
    trig_cfg_pkg::wb_data_t rd;
    wb_access(1'b1, a, d, rd);
    if (a == trig_cfg_pkg::reg_chan_en) m_en = d[trig_cfg_pkg::num_chan-1:0];
    else if (a == trig_cfg_pkg::reg_thres) m_thres = d[22:0];
    else if (a >= 2 && a <= 6) m_burst[a-2] = d[22:0];
  endtask

  task automatic read_check(input trig_cfg_pkg::wb_addr_t a,
      input trig_cfg_pkg::wb_data_t exp, input string name);
    trig_cfg_pkg::wb_data_t rd;
    wb_access(1'b0, a, '0, rd);
    check_word(rd, exp, name);
  endtask

  // trigger levels in time order, lowest bit first
  task automatic drive_levels(input logic [7:0] lv, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      trigger <= lv[i];
    end
    @(posedge clk);
    trigger <= 1'b0;
    @(negedge clk);
    while (!m_idle) @(negedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic pulse_readout();
    @(posedge clk) readout_done <= 1'b1;
    @(posedge clk) readout_done <= 1'b0;
  endtask

  initial begin
    {wb_cyc, wb_stb, wb_we, trigger, reset_trig_num, reset_trig_timestamp} = '0;
    {readout_done, stall_en, rec_ready} = '0;
    wb_adr = '0;
    wb_dat_w = '0;
    m_en = '0;
    m_thres = '0;
    for (int i = 0; i < trig_cfg_pkg::num_chan; i++) m_burst[i] = '0;
    {cycles, rec_errs, word_errs, flag_errs, other_errs, assert_errs} = '0;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // register access
    write_reg(trig_cfg_pkg::reg_chan_en, 32'h15);
    write_reg(trig_cfg_pkg::reg_thres, 32'd30);
    for (int i = 0; i < trig_cfg_pkg::num_chan; i++)
      write_reg(trig_cfg_pkg::wb_addr_t'(trig_cfg_pkg::reg_burst_base + i),
                trig_cfg_pkg::wb_data_t'(10 * i + 3));
    read_check(trig_cfg_pkg::reg_chan_en, 32'h15, "chan_en");
    read_check(trig_cfg_pkg::reg_thres, 32'd30, "thres");
    for (int i = 0; i < trig_cfg_pkg::num_chan; i++)
      read_check(trig_cfg_pkg::wb_addr_t'(trig_cfg_pkg::reg_burst_base + i),
                 trig_cfg_pkg::wb_data_t'(10 * i + 3), "burst");
    read_check(4'd7, '0, "unmapped");

    // classification under back-pressure
    stall_en <= 1'b1;
    for (int n = 0; n < 10; n++) begin
      w = 1 + ($unsigned($random(seed)) % 6);
      drive_levels(8'((1 << w) - 1), w);
    end
    drive_levels(8'b1101, 4);  // gap in the pulse
    stall_en <= 1'b0;
    read_check(trig_cfg_pkg::reg_trig_num, 32'(m_num), "trig_num");

    // almost full
    pulse_readout();
    drive_levels(8'b1, 1);
    @(negedge clk);
    check_flag(ddr3_almost_full, |model_af(), "ddr3_almost_full");
    read_check(trig_cfg_pkg::reg_almost_full, 32'(model_af()), "almost_full reg");
    pulse_readout();
    @(negedge clk);
    check_flag(ddr3_almost_full, 1'b0, "ddr3_almost_full");
    read_check(trig_cfg_pkg::reg_almost_full, '0, "almost_full reg");

    // overflow
    write_reg(trig_cfg_pkg::reg_chan_en, 32'h1);
    write_reg(trig_cfg_pkg::reg_burst_base, 32'd300000);
    drive_levels(8'b1111, 4);
    drive_levels(8'b1111, 1);
    repeat (8) @(posedge clk);
    read_check(trig_cfg_pkg::reg_ovf_count, 32'd1, "ovf_count");
    pulse_readout();
    drive_levels(8'b1, 1);
    write_reg(trig_cfg_pkg::reg_burst_base, 32'd3);  // room for more triggers

    // counter resets
    @(posedge clk) reset_trig_num <= 1'b1;
    @(posedge clk) reset_trig_num <= 1'b0;
    drive_levels(8'b111, 3);
    pulse_readout();
    drive_levels(8'b11111, 5);
    @(posedge clk) reset_trig_timestamp <= 1'b1;
    @(posedge clk) reset_trig_timestamp <= 1'b0;
    repeat (7) @(posedge clk);
    drive_levels(8'b11, 2);
    repeat (4) @(posedge clk);

    if (rec_q.size() != 0) begin
      other_errs++;
      $display("%0d expected records never arrived", rec_q.size());
    end
    assert_errs = pulse_trigger_top_i.pulse_trigger_checker_i.fail_count;
    $display("errors: rec %0d word %0d flag %0d other %0d assert %0d",
             rec_errs, word_errs, flag_errs, other_errs, assert_errs);
    if (rec_errs + word_errs + flag_errs + other_errs + assert_errs == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== sources.f ====
trig_cfg_pkg.sv
trig_rec_pkg.sv
chan_occ_if.sv
trig_config_regs.sv
chan_occupancy.sv
pulse_trigger_fsm.sv
pulse_trigger_top.sv
pulse_trigger_checker.sv
tb_pulse_trigger.sv
